/* compile.f */
+incdir+include
src/copper_pkg.sv
src/copper_ctrl_reg.sv
src/copper_beam_cmp.sv
src/copper_exec.sv
src/copper_top.sv
test/copper_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the copper testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module copper_tb \
    -o copper_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/copper_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All tests passed$" sim.log; then
    exit 0
fi
exit 1

/* src/copper_beam_cmp.sv */
`default_nettype none
`timescale 1ns/1ps

module copper_beam_cmp (
    input  wire logic                             clk,
    input  wire logic                             cmp_load_i,
    input  wire logic [copper_pkg::POS_W-1:0]     h_count_i,
    input  wire logic [copper_pkg::POS_W-1:0]     v_count_i,
    input  wire logic [copper_pkg::POS_W-1:0]     wait_x_i,
    input  wire logic [copper_pkg::POS_W-1:0]     wait_y_i,
    input  wire logic [1:0]                       flags_i,
    output      logic                             cond_met_o
);

    logic h_reached;
    logic v_reached;
    logic h_ok;
    logic v_ok;

    // Compare once in PRECOMP, result held for EXEC
    // Keeps the 11-bit compares off the execute path
    always_ff @(posedge clk) begin
        if (cmp_load_i) begin
            h_reached <= h_count_i >= wait_x_i;
            v_reached <= v_count_i >= wait_y_i;
        end
    end

    // An ignored axis counts as reached
    always_comb begin
        h_ok       = flags_i[copper_pkg::FLAG_IGNORE_H] || h_reached;
        v_ok       = flags_i[copper_pkg::FLAG_IGNORE_V] || v_reached;
        // Both ignored gives always met
        cond_met_o = h_ok && v_ok;
    end

endmodule

`default_nettype wire

/* src/copper_ctrl_reg.sv */
`default_nettype none
`timescale 1ns/1ps

module copper_ctrl_reg #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  wire logic                                 clk,
    input  wire logic                                 copp_reset,
    input  wire logic                                 copp_reg_wr_i,
    input  wire logic [copper_pkg::REG_NUM_W-1:0]     copp_reg_num_i,
    input  wire logic [copper_pkg::WORD_W-1:0]        copp_reg_data_i,
    input  wire logic [copper_pkg::POS_W-1:0]         h_count_i,
    input  wire logic [copper_pkg::POS_W-1:0]         v_count_i,
    output      logic                                 copper_en_o,
    output      logic [copper_pkg::PC_W-1:0]          init_pc_o,
    output      logic                                 frame_restart_o
);

    // Beam position of the restart, a few pixels ahead of the new frame
    localparam logic [copper_pkg::POS_W-1:0] RESTART_H =
        copper_pkg::POS_W'(H_TOTAL - copper_pkg::RESTART_H_OFFSET);
    localparam logic [copper_pkg::POS_W-1:0] RESTART_V =
        copper_pkg::POS_W'(V_TOTAL - 1);

    // Host write to the control register
    // Enable in bit 15, initial PC in the low bits
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en_o <= 1'b0;
            init_pc_o   <= '0;
        end else if (copp_reg_wr_i && copp_reg_num_i == copper_pkg::XR_COPP_CTRL) begin
            copper_en_o <= copp_reg_data_i[15];
            init_pc_o   <= copp_reg_data_i[copper_pkg::PC_W-1:0];
        end
    end

    // True for the one pixel that matches the restart position
    always_comb begin
        frame_restart_o = (h_count_i == RESTART_H) && (v_count_i == RESTART_V);
    end

    // Beam counter moves every cycle, so the match cannot repeat back to back
    a_restart_single: assert property (
        @(posedge clk) disable iff (copp_reset)
        frame_restart_o |=> !frame_restart_o
    ) else $error("frame restart held for more than one cycle");

endmodule

`default_nettype wire

/* src/copper_exec.sv */
`default_nettype none
`timescale 1ns/1ps

module copper_exec (
    input  wire logic                                 clk,
    input  wire logic                                 copp_reset,
    input  wire logic                                 frame_restart_i,
    input  wire logic                                 copper_en_i,
    input  wire logic [copper_pkg::PC_W-1:0]          init_pc_i,
    input  wire logic [copper_pkg::WORD_W-1:0]        coppermem_e_rd_data_i,
    input  wire logic [copper_pkg::WORD_W-1:0]        coppermem_o_rd_data_i,
    input  wire logic                                 cond_met_i,
    input  wire logic                                 regs_xr_reg_sel_i,
    input  wire logic                                 regs_tilemem_sel_i,
    input  wire logic                                 regs_colormem_sel_i,
    input  wire logic                                 regs_coppermem_sel_i,
    output      logic                                 coppermem_rd_en_o,
    output      logic [copper_pkg::PC_W-1:0]          coppermem_rd_addr_o,
    output      logic                                 cmp_load_o,
    output      logic [copper_pkg::POS_W-1:0]         wait_x_o,
    output      logic [copper_pkg::POS_W-1:0]         wait_y_o,
    output      logic [1:0]                           flags_o,
    output      logic                                 xr_wr_en_o,
    output      logic [copper_pkg::XR_ADDR_W-1:0]     xr_wr_addr_o,
    output      logic [copper_pkg::WORD_W-1:0]        xr_wr_data_o
);

    copper_pkg::ex_state_e state;

    // Word 1 in the upper half, word 2 in the lower half
    logic [2*copper_pkg::WORD_W-1:0] r_insn;
    logic [copper_pkg::PC_W-1:0]     pc;
    logic                            wait_met;

    // Memory address is always the program counter
    assign coppermem_rd_addr_o = pc;

    // WAIT/SKIP fields, Y from word 1 and X plus flags from word 2
    assign wait_y_o   = r_insn[26:16];
    assign wait_x_o   = r_insn[14:4];
    assign flags_o    = r_insn[1:0];
    assign cmp_load_o = (state == copper_pkg::PRECOMP);

    // WAIT with both axes ignored never completes, only frame restart ends it
    assign wait_met = cond_met_i && !(&r_insn[1:0]);

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state             <= copper_pkg::INIT;
            pc                <= '0;
            coppermem_rd_en_o <= 1'b0;
            xr_wr_en_o        <= 1'b0;
        end else if (frame_restart_i) begin
            // New frame, restart at the initial PC
            state             <= copper_pkg::INIT;
            pc                <= init_pc_i;
            coppermem_rd_en_o <= 1'b0;
            xr_wr_en_o        <= 1'b0;
        end else begin
            // Write strobe lasts a single cycle
            xr_wr_en_o <= 1'b0;
            case (state)
                copper_pkg::INIT: begin
                    // Start the first fetch once enabled
                    if (copper_en_i) begin
                        state             <= copper_pkg::FETCH_WAIT;
                        coppermem_rd_en_o <= 1'b1;
                    end
                end
                copper_pkg::FETCH_WAIT: begin
                    // Banks read this cycle, step past the instruction
                    if (copper_en_i) begin
                        state <= copper_pkg::LATCH;
                        pc    <= pc + 1'b1;
                    end else begin
                        state             <= copper_pkg::INIT;
                        coppermem_rd_en_o <= 1'b0;
                    end
                end
                copper_pkg::LATCH: begin
                    r_insn            <= {coppermem_e_rd_data_i, coppermem_o_rd_data_i};
                    coppermem_rd_en_o <= 1'b0;
                    state             <= copper_pkg::PRECOMP;
                end
                copper_pkg::PRECOMP: begin
                    // Beam compare loads here
                    state <= copper_pkg::EXEC;
                end
                copper_pkg::EXEC: begin
                    // Default is next fetch, MOVE stall and WAIT override below
                    state             <= copper_pkg::FETCH_WAIT;
                    coppermem_rd_en_o <= 1'b1;
                    xr_wr_data_o      <= r_insn[15:0];
                    case (r_insn[31:28])
                        copper_pkg::WAIT: begin
                            if (!wait_met) begin
                                state             <= copper_pkg::PRECOMP;
                                coppermem_rd_en_o <= 1'b0;
                            end
                        end
                        copper_pkg::SKIP: begin
                            // Met condition drops the next instruction
                            if (cond_met_i) begin
                                pc <= pc + 1'b1;
                            end
                        end
                        copper_pkg::JMP: begin
                            pc <= r_insn[25:16];
                        end
                        copper_pkg::MOVER: begin
                            xr_wr_addr_o <= {copper_pkg::XR_REG_BASE[15:8], r_insn[23:16]};
                            if (regs_xr_reg_sel_i) begin
                                state             <= copper_pkg::EXEC;
                                coppermem_rd_en_o <= 1'b0;
                            end else begin
                                xr_wr_en_o <= 1'b1;
                            end
                        end
                        copper_pkg::MOVEF: begin
                            xr_wr_addr_o <= {copper_pkg::XR_TILE_BASE[15:12], r_insn[27:16]};
                            if (regs_tilemem_sel_i) begin
                                state             <= copper_pkg::EXEC;
                                coppermem_rd_en_o <= 1'b0;
                            end else begin
                                xr_wr_en_o <= 1'b1;
                            end
                        end
                        copper_pkg::MOVEP: begin
                            xr_wr_addr_o <= {copper_pkg::XR_COLOR_BASE[15:8], r_insn[23:16]};
                            if (regs_colormem_sel_i) begin
                                state             <= copper_pkg::EXEC;
                                coppermem_rd_en_o <= 1'b0;
                            end else begin
                                xr_wr_en_o <= 1'b1;
                            end
                        end
                        copper_pkg::MOVEC: begin
                            xr_wr_addr_o <= {copper_pkg::XR_COPPER_BASE[15:11], r_insn[26:16]};
                            if (regs_coppermem_sel_i) begin
                                state             <= copper_pkg::EXEC;
                                coppermem_rd_en_o <= 1'b0;
                            end else begin
                                xr_wr_en_o <= 1'b1;
                            end
                        end
                        // Illegal opcode falls through as a four-cycle no-op
                        default: ;
                    endcase
                end
                default: state <= copper_pkg::INIT;
            endcase
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (copp_reset)
        state inside {copper_pkg::INIT, copper_pkg::FETCH_WAIT, copper_pkg::LATCH,
                      copper_pkg::PRECOMP, copper_pkg::EXEC}
    ) else $error("execute state out of range");

    // Every write is followed by a fetch, so two in a row would be a lost instruction
    a_wr_single: assert property (
        @(posedge clk) disable iff (copp_reset)
        xr_wr_en_o |=> !xr_wr_en_o
    ) else $error("XR write strobe held for more than one cycle");

endmodule

`default_nettype wire

/* src/copper_pkg.sv */
package copper_pkg;

    // Program counter and copper memory address width
    localparam int PC_W      = 10;
    // Beam counters and WAIT/SKIP positions
    localparam int POS_W     = 11;
    // Memory word and XR write data
    localparam int WORD_W    = 16;
    localparam int XR_ADDR_W = 16;
    localparam int REG_NUM_W = 4;

    // Opcode sits in the top nibble of word 1
    typedef enum logic [3:0] {
        WAIT  = 4'b0000,
        SKIP  = 4'b0010,
        JMP   = 4'b0100,
        MOVER = 4'b1001,
        MOVEF = 4'b1010,
        MOVEP = 4'b1011,
        MOVEC = 4'b1100
    } opcode_e;

    // Execute sequencer states
    typedef enum logic [2:0] {
        INIT       = 3'd0,
        FETCH_WAIT = 3'd1,
        LATCH      = 3'd2,
        PRECOMP    = 3'd3,
        EXEC       = 3'd4
    } ex_state_e;

    // Copper control register number
    localparam logic [REG_NUM_W-1:0] XR_COPP_CTRL = 4'd1;

    // MOVE target bases
    // Register space keeps 8 address bits
    localparam logic [XR_ADDR_W-1:0] XR_REG_BASE    = 16'h0000;
    // Tile memory keeps 12 address bits
    localparam logic [XR_ADDR_W-1:0] XR_TILE_BASE   = 16'h4000;
    // Color memory keeps 8 address bits
    localparam logic [XR_ADDR_W-1:0] XR_COLOR_BASE  = 16'h8000;
    // Copper memory keeps 11 address bits
    localparam logic [XR_ADDR_W-1:0] XR_COPPER_BASE = 16'hC000;

    // WAIT/SKIP flag bits
    localparam int FLAG_IGNORE_V = 0;
    localparam int FLAG_IGNORE_H = 1;

    // Restart this many pixels before the end of the last line
    localparam int RESTART_H_OFFSET = 5;

endpackage

/* src/copper_top.sv */
`default_nettype none
`timescale 1ns/1ps

module copper_top #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  wire logic                                 clk,
    input  wire logic                                 copp_reset,
    input  wire logic                                 copp_reg_wr_i,
    input  wire logic [copper_pkg::REG_NUM_W-1:0]     copp_reg_num_i,
    input  wire logic [copper_pkg::WORD_W-1:0]        copp_reg_data_i,
    input  wire logic [copper_pkg::POS_W-1:0]         h_count_i,
    input  wire logic [copper_pkg::POS_W-1:0]         v_count_i,
    input  wire logic                                 regs_xr_reg_sel_i,
    input  wire logic                                 regs_tilemem_sel_i,
    input  wire logic                                 regs_colormem_sel_i,
    input  wire logic                                 regs_coppermem_sel_i,
    input  wire logic [copper_pkg::WORD_W-1:0]        coppermem_e_rd_data_i,
    input  wire logic [copper_pkg::WORD_W-1:0]        coppermem_o_rd_data_i,
    output      logic                                 coppermem_rd_en_o,
    output      logic [copper_pkg::PC_W-1:0]          coppermem_rd_addr_o,
    output      logic                                 xr_wr_en_o,
    output      logic [copper_pkg::XR_ADDR_W-1:0]     xr_wr_addr_o,
    output      logic [copper_pkg::WORD_W-1:0]        xr_wr_data_o
);

    logic                            copper_en;
    logic [copper_pkg::PC_W-1:0]     init_pc;
    logic                            frame_restart;
    logic                            cmp_load;
    logic [copper_pkg::POS_W-1:0]    wait_x;
    logic [copper_pkg::POS_W-1:0]    wait_y;
    logic [1:0]                      flags;
    logic                            cond_met;

    // Control register and frame restart
    copper_ctrl_reg #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) ctrl0 (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .copp_reg_wr_i   (copp_reg_wr_i),
        .copp_reg_num_i  (copp_reg_num_i),
        .copp_reg_data_i (copp_reg_data_i),
        .h_count_i       (h_count_i),
        .v_count_i       (v_count_i),
        .copper_en_o     (copper_en),
        .init_pc_o       (init_pc),
        .frame_restart_o (frame_restart)
    );

    // Beam position compare for WAIT and SKIP
    copper_beam_cmp cmp0 (
        .clk        (clk),
        .cmp_load_i (cmp_load),
        .h_count_i  (h_count_i),
        .v_count_i  (v_count_i),
        .wait_x_i   (wait_x),
        .wait_y_i   (wait_y),
        .flags_i    (flags),
        .cond_met_o (cond_met)
    );

    copper_exec exec0 (
        .clk                   (clk),
        .copp_reset            (copp_reset),
        .frame_restart_i       (frame_restart),
        .copper_en_i           (copper_en),
        .init_pc_i             (init_pc),
        .coppermem_e_rd_data_i (coppermem_e_rd_data_i),
        .coppermem_o_rd_data_i (coppermem_o_rd_data_i),
        .cond_met_i            (cond_met),
        .regs_xr_reg_sel_i     (regs_xr_reg_sel_i),
        .regs_tilemem_sel_i    (regs_tilemem_sel_i),
        .regs_colormem_sel_i   (regs_colormem_sel_i),
        .regs_coppermem_sel_i  (regs_coppermem_sel_i),
        .coppermem_rd_en_o     (coppermem_rd_en_o),
        .coppermem_rd_addr_o   (coppermem_rd_addr_o),
        .cmp_load_o            (cmp_load),
        .wait_x_o              (wait_x),
        .wait_y_o              (wait_y),
        .flags_o               (flags),
        .xr_wr_en_o            (xr_wr_en_o),
        .xr_wr_addr_o          (xr_wr_addr_o),
        .xr_wr_data_o          (xr_wr_data_o)
    );

endmodule

`default_nettype wire

/* include/copper_tb_prog.svh */
`ifndef COPPER_TB_PROG_SVH
`define COPPER_TB_PROG_SVH

// Program start, also the init_pc given to the control register
localparam logic [9:0] PROG_BASE = 10'h020;
localparam int PROG_LEN = 21;

// Word 1 in the upper half, word 2 in the lower half
localparam logic [31:0] PROG [PROG_LEN] = '{
    32'h9005_1234,  // MOVER 0x05
    32'hAABC_5A5A,  // MOVEF 0xABC
    32'h9007_1111,  // MOVER 0x07
    32'hB03C_0F0F,  // MOVEP 0x3C, select held high
    32'hC2A5_BEEF,  // MOVEC 0x2A5
    32'h0002_0140,  // WAIT x 20, y 2
    32'h9010_2222,
    32'h0004_0642,  // WAIT y 4, ignore H, x 100 never reached
    32'hA123_3333,
    32'h0064_01E1,  // WAIT x 30, ignore V, y 100 never reached
    32'hB011_4444,
    32'h2000_0000,  // SKIP x 0, y 0, always met
    32'h9066_DEAD,  // Dropped
    32'h200F_0002,  // SKIP y 15, ignore H, not met
    32'h9067_5555,
    32'h4032_0000,  // JMP to index 18
    32'hC001_BAD0,  // Never runs
    32'hB002_BAD1,  // Never runs
    32'hC7FF_6666,
    32'h0000_0003,  // Halt until frame restart
    32'h90EE_BAD2   // Behind the halt, never runs
};

typedef struct packed {
    logic [15:0] addr;
    logic [15:0] data;
    logic [10:0] min_h;
    logic [10:0] min_v;
    logic        hold;
} wr_exp_t;

// Address, data, earliest h, earliest v, colormem select held
localparam int EXP_LEN = 10;
localparam wr_exp_t EXP [EXP_LEN] = '{
    '{16'h0005, 16'h1234, 11'd0,  11'd0, 1'b0},
    '{16'h4ABC, 16'h5A5A, 11'd0,  11'd0, 1'b0},
    '{16'h0007, 16'h1111, 11'd0,  11'd0, 1'b0},
    '{16'h803C, 16'h0F0F, 11'd0,  11'd0, 1'b1},
    '{16'hC2A5, 16'hBEEF, 11'd0,  11'd0, 1'b0},
    '{16'h0010, 16'h2222, 11'd20, 11'd2, 1'b0},
    '{16'h4123, 16'h3333, 11'd0,  11'd4, 1'b0},
    '{16'h8011, 16'h4444, 11'd30, 11'd0, 1'b0},
    '{16'h0067, 16'h5555, 11'd0,  11'd0, 1'b0},
    '{16'hC7FF, 16'h6666, 11'd0,  11'd0, 1'b0}
};

`endif

/* test/copper_tb.sv */
`timescale 1ns/1ps

module copper_tb;

    localparam int H_TOTAL = 64;
    localparam int V_TOTAL = 16;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // First write of a pass can sit behind a whole halted frame
    localparam int WR_TIMEOUT = 2 * FRAME_CYCLES;
    localparam logic [10:0] H_LAST = 11'(H_TOTAL - 1);
    localparam logic [10:0] V_LAST = 11'(V_TOTAL - 1);
    // Restart pixel, five before the end of the last line
    localparam logic [10:0] RESTART_H = 11'(H_TOTAL - 5);

    logic        clk;
    logic        copp_reset;
    logic        copp_reg_wr;
    logic [3:0]  copp_reg_num;
    logic [15:0] copp_reg_data;
    logic [10:0] h_count;
    logic [10:0] v_count;
    logic        xr_reg_sel;
    logic        tilemem_sel;
    logic        colormem_sel;
    logic        coppermem_sel;
    logic [15:0] mem_e_data;
    logic [15:0] mem_o_data;
    logic        mem_rd_en;
    logic [9:0]  mem_rd_addr;
    logic        xr_wr_en;
    logic [15:0] xr_wr_addr;
    logic [15:0] xr_wr_data;

    // Even and odd instruction banks
    logic [15:0] bank_e [1024];
    logic [15:0] bank_o [1024];
    logic        rd_q;
    logic [9:0]  addr_q;
    logic [15:0] lfsr;
    int          errors;
    int          checks;

    `include "copper_tb_prog.svh"

    copper_top #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) dut0 (
        .clk                   (clk),
        .copp_reset            (copp_reset),
        .copp_reg_wr_i         (copp_reg_wr),
        .copp_reg_num_i        (copp_reg_num),
        .copp_reg_data_i       (copp_reg_data),
        .h_count_i             (h_count),
        .v_count_i             (v_count),
        .regs_xr_reg_sel_i     (xr_reg_sel),
        .regs_tilemem_sel_i    (tilemem_sel),
        .regs_colormem_sel_i   (colormem_sel),
        .regs_coppermem_sel_i  (coppermem_sel),
        .coppermem_e_rd_data_i (mem_e_data),
        .coppermem_o_rd_data_i (mem_o_data),
        .coppermem_rd_en_o     (mem_rd_en),
        .coppermem_rd_addr_o   (mem_rd_addr),
        .xr_wr_en_o            (xr_wr_en),
        .xr_wr_addr_o          (xr_wr_addr),
        .xr_wr_data_o          (xr_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Beam counters and registered bank read, updated just after the edge
    always @(posedge clk) begin
        rd_q   = mem_rd_en;
        addr_q = mem_rd_addr;
        #1;
        if (rd_q) begin
            mem_e_data = bank_e[addr_q];
            mem_o_data = bank_o[addr_q];
        end
        if (h_count == H_LAST) begin
            h_count = 11'd0;
            v_count = (v_count == V_LAST) ? 11'd0 : v_count + 11'd1;
        end else begin
            h_count = h_count + 11'd1;
        end
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic check_hex(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout while waiting for %s", what);
    endtask

    // Compares one observed write with its table entry
    task automatic compare_write(input int idx, input bit seen_restart);
        check_hex("xr_wr_addr_o", xr_wr_addr, EXP[idx].addr);
        check_hex("xr_wr_data_o", xr_wr_data, EXP[idx].data);
        checks++;
        if (h_count < EXP[idx].min_h || v_count < EXP[idx].min_v) begin
            errors++;
            $display("Write to %h came at beam %0d,%0d before its wait position %0d,%0d",
                     xr_wr_addr, h_count, v_count, EXP[idx].min_h, EXP[idx].min_v);
        end
        // First write of a frame only after the restart point
        checks++;
        if (idx == 0 && !seen_restart) begin
            errors++;
            $display("Program started without passing the frame restart position");
        end
    endtask

    task automatic load_banks();
        // Unused words are illegal opcodes tagged with their own address
        for (int i = 0; i < 1024; i++) begin
            bank_e[i[9:0]] = {4'h1, 2'b00, i[9:0]};
            bank_o[i[9:0]] = {6'b000000, i[9:0]};
        end
        // Address 0 halts, so the first run waits for a frame restart
        bank_e[0] = 16'h0000;
        bank_o[0] = 16'h0003;
        for (int i = 0; i < PROG_LEN; i++) begin
            bank_e[PROG_BASE + i[9:0]] = PROG[i][31:16];
            bank_o[PROG_BASE + i[9:0]] = PROG[i][15:0];
        end
    endtask

    // Holds the color memory select for 4 to 19 cycles
    task automatic hold_colormem_sel();
        logic [3:0] bits;
        int         cycles;
        bits = 4'd0;
        for (int b = 0; b < 4; b++) begin
            bits = {bits[2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        cycles = 4 + int'(bits);
        @(posedge clk);
        #1 colormem_sel = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            check_hex("xr_wr_en_o", {15'd0, xr_wr_en}, 16'h0000);
        end
        @(posedge clk);
        #1 colormem_sel = 1'b0;
        // Select was still high at the last edge
        @(negedge clk);
        check_hex("xr_wr_en_o", {15'd0, xr_wr_en}, 16'h0000);
    endtask

    initial begin
        int n;
        bit seen_restart;
        bit timed_out;
        copp_reset    = 1'b1;
        copp_reg_wr   = 1'b0;
        copp_reg_num  = 4'd0;
        copp_reg_data = 16'h0000;
        h_count       = 11'd0;
        v_count       = 11'd0;
        xr_reg_sel    = 1'b0;
        tilemem_sel   = 1'b0;
        colormem_sel  = 1'b0;
        coppermem_sel = 1'b0;
        mem_e_data    = 16'h0000;
        mem_o_data    = 16'h0000;
        lfsr          = 16'd25;
        errors        = 0;
        checks        = 0;
        timed_out     = 1'b0;
        load_banks();
        repeat (10) @(posedge clk);
        #1 copp_reset = 1'b0;

        // Disabled copper stays quiet for a whole frame
        for (n = 0; n < FRAME_CYCLES; n++) begin
            @(negedge clk);
            check_hex("coppermem_rd_en_o", {15'd0, mem_rd_en}, 16'h0000);
            check_hex("xr_wr_en_o", {15'd0, xr_wr_en}, 16'h0000);
        end

        // Enable with the program start as init_pc
        @(posedge clk);
        #1;
        copp_reg_wr   = 1'b1;
        copp_reg_num  = 4'd1;
        copp_reg_data = {1'b1, 5'd0, PROG_BASE};
        @(posedge clk);
        #1 copp_reg_wr = 1'b0;

        // Two frames, the program must repeat from init_pc
        for (int pass = 0; pass < 2 && !timed_out; pass++) begin
            for (int idx = 0; idx < EXP_LEN && !timed_out; idx++) begin
                if (EXP[idx].hold) begin
                    hold_colormem_sel();
                end
                n = 0;
                seen_restart = 1'b0;
                do begin
                    @(negedge clk);
                    if (h_count == RESTART_H && v_count == V_LAST) begin
                        seen_restart = 1'b1;
                    end
                    n++;
                end while (xr_wr_en !== 1'b1 && n < WR_TIMEOUT);
                if (xr_wr_en !== 1'b1) begin
                    report_timeout("an XR write");
                    timed_out = 1'b1;
                end else begin
                    compare_write(idx, seen_restart);
                end
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
